// ==== hw/sw_pkg.sv ====
package sw_pkg;

    // ------------------------------
    // data types
    // ------------------------------
    localparam int SCORE_W = 8;

    typedef logic [1:0]                base_t;   // nucleotide code
    typedef logic signed [SCORE_W-1:0] score_t;  // alignment score

    // ------------------------------
    // scoring constants
    // ------------------------------
    localparam score_t MATCH      = score_t'(2);
    localparam score_t MISMATCH   = score_t'(-1);
    localparam score_t GAP_OPEN   = score_t'(-2);  // first cell of a gap
    localparam score_t GAP_EXTEND = score_t'(-1);  // every further gap cell

    // substitution score of one base pair
    function automatic score_t sub_score(base_t ref_base, base_t query_base);
        if (ref_base == query_base)
        begin
            return MATCH;
        end
        return MISMATCH;
    endfunction

    // signed maximum of two scores
    function automatic score_t max_score(score_t a, score_t b);
        if (a > b)
        begin
            return a;
        end
        return b;
    endfunction

endpackage

// ==== hw/sw_pe.sv ====
`timescale 1ns/1ps

module sw_pe
    import sw_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   load_i,
    input  base_t  query_i,
    input  base_t  ref_i,
    input  logic   ref_valid_i,
    input  score_t h_left_i,
    input  score_t i_left_i,
    input  score_t h_diag_i,
    output base_t  ref_o,
    output logic   ref_valid_o,
    output score_t h_o,
    output score_t i_o,
    output score_t h_diag_o
);

    base_t  query_q;
    base_t  query_cur;
    score_t d_q;        // vertical gap score of the last row
    score_t s_val;
    score_t diag_sum;   // diagonal move before the zero floor
    score_t i_new;
    score_t d_new;
    score_t h_new;

    // the load cycle is also the first compute cycle of this cell
    assign query_cur = load_i ? query_i : query_q;
    assign s_val     = sub_score(ref_i, query_cur);

    // ------------------------------
    // recurrences
    // ------------------------------
    assign i_new    = max_score(h_left_i + GAP_OPEN, i_left_i + GAP_EXTEND);  // gap along query
    assign d_new    = max_score(h_o + GAP_OPEN, d_q + GAP_EXTEND);            // gap along ref
    assign diag_sum = h_diag_i + s_val;
    assign h_new    = max_score(max_score(diag_sum, '0), max_score(i_new, d_new));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ref_valid_o <= 1'b0;
            h_o         <= '0;
            i_o         <= GAP_OPEN;
            d_q         <= GAP_OPEN;
            h_diag_o    <= '0;
        end
        else
        begin
            ref_valid_o <= ref_valid_i;
            h_diag_o    <= h_o;         // previous row becomes next cell's diagonal
            if (ref_valid_i)
            begin
                h_o <= h_new;
                i_o <= i_new;
                d_q <= d_new;
            end
            else
            begin
                // row 0 boundary for the next run
                h_o <= '0;
                i_o <= GAP_OPEN;
                d_q <= GAP_OPEN;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        ref_o <= ref_i;
        if (load_i)
        begin
            query_q <= query_i;
        end
    end

    // diagonal sum fits in score_t
    a_diag_no_wrap : assert property (@(posedge clk) disable iff (reset)
        ref_valid_i |-> int'(diag_sum) == int'(h_diag_i) + int'(s_val))
        else $error("sw_pe: score overflow on diagonal H %0d", h_diag_i);

endmodule

// ==== hw/sw_array.sv ====
`timescale 1ns/1ps

module sw_array
    import sw_pkg::*;
#(
    parameter int NUM_QUERY = 8
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_QUERY-1:0] query_load_i,
    input  base_t                data_query_i,
    input  base_t                data_ref_i,
    input  logic                 ref_valid_i,
    output score_t               h_all_o [NUM_QUERY],
    output logic [NUM_QUERY-1:0] cell_valid_o
);

    base_t  ref_q;      // input stage, lines up with the controller strobes
    base_t  query_q;

    // neighbour links, entry k feeds cell k
    base_t  ref_chain  [NUM_QUERY+1];
    logic   vld_chain  [NUM_QUERY+1];
    score_t h_chain    [NUM_QUERY+1];
    score_t i_chain    [NUM_QUERY+1];
    score_t diag_chain [NUM_QUERY+1];

    always_ff @(posedge clk)
    begin
        ref_q   <= data_ref_i;
        query_q <= data_query_i;
    end

    // left boundary of the matrix
    assign ref_chain[0]  = ref_q;
    assign vld_chain[0]  = ref_valid_i;
    assign h_chain[0]    = '0;
    assign i_chain[0]    = GAP_OPEN;
    assign diag_chain[0] = '0;

    // ------------------------------
    // cell chain
    // ------------------------------
    for (genvar k = 0; k < NUM_QUERY; k++)
    begin : g_cell
        sw_pe u_pe (
            .clk         (clk),
            .reset       (reset),
            .load_i      (query_load_i[k]),
            .query_i     (query_q),
            .ref_i       (ref_chain[k]),
            .ref_valid_i (vld_chain[k]),
            .h_left_i    (h_chain[k]),
            .i_left_i    (i_chain[k]),
            .h_diag_i    (diag_chain[k]),
            .ref_o       (ref_chain[k+1]),
            .ref_valid_o (vld_chain[k+1]),
            .h_o         (h_chain[k+1]),
            .i_o         (i_chain[k+1]),
            .h_diag_o    (diag_chain[k+1])
        );

        assign h_all_o[k]      = h_chain[k+1];
        assign cell_valid_o[k] = vld_chain[k+1];  // h holds a real cell
    end

endmodule

// ==== hw/sw_ctrl.sv ====
`timescale 1ns/1ps

module sw_ctrl #(
    parameter int NUM_REF   = 16,
    parameter int NUM_QUERY = 8
)
(
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       valid_i,
    output logic [NUM_QUERY-1:0]                       query_load_o,
    output logic                                       ref_valid_o,
    output logic                                       clear_o,
    output logic [$clog2(NUM_REF + NUM_QUERY + 1)-1:0] diag_o,
    output logic                                       finish_o
);

    localparam int               CNT_W      = $clog2(NUM_REF + NUM_QUERY + 1);
    localparam logic [CNT_W-1:0] LOAD_LAST  = CNT_W'(NUM_REF - 1);
    localparam logic [CNT_W-1:0] DRAIN_LAST = CNT_W'(NUM_REF + NUM_QUERY);

    typedef enum logic [1:0] {S_IDLE, S_LOAD, S_DRAIN} state_t;

    state_t           state;
    logic [CNT_W-1:0] count;    // equals the anti-diagonal seen by the tracker

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state    <= S_IDLE;
            count    <= '0;
            finish_o <= 1'b0;
        end
        else
        begin
            finish_o <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (valid_i)
                    begin
                        state <= S_LOAD;
                        count <= '0;
                    end
                end
                S_LOAD:
                begin
                    count <= count + 1'b1;
                    if (count == LOAD_LAST)
                    begin
                        state <= S_DRAIN;
                    end
                end
                S_DRAIN:
                begin
                    if (count == DRAIN_LAST)
                    begin
                        state    <= S_IDLE;
                        finish_o <= 1'b1;   // last cell went through the tracker
                    end
                    else
                    begin
                        count <= count + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ------------------------------
    // strobes
    // ------------------------------
    assign ref_valid_o = (state == S_LOAD);
    assign clear_o     = (state == S_LOAD) && (count == '0);
    assign diag_o      = count;

    always_comb
    begin
        for (int j = 0; j < NUM_QUERY; j++)
        begin
            query_load_o[j] = (state == S_LOAD) && (count == CNT_W'(j));
        end
    end

    a_valid_held : assert property (@(posedge clk) disable iff (reset)
        (state == S_LOAD && count != LOAD_LAST) |-> valid_i)
        else $error("sw_ctrl: valid_i dropped during load");

endmodule

// ==== hw/sw_max_tracker.sv ====
`timescale 1ns/1ps

module sw_max_tracker
    import sw_pkg::*;
#(
    parameter int NUM_REF   = 16,
    parameter int NUM_QUERY = 8
)
(
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       clear_i,
    input  logic [$clog2(NUM_REF + NUM_QUERY + 1)-1:0] diag_i,
    input  score_t                                     h_all_i [NUM_QUERY],
    input  logic [NUM_QUERY-1:0]                       cell_valid_i,
    output score_t                                     max_o,
    output logic [$clog2(NUM_REF + 1)-1:0]             pos_ref_o,
    output logic [$clog2(NUM_QUERY + 1)-1:0]           pos_query_o
);

    localparam int DIAG_W = $clog2(NUM_REF + NUM_QUERY + 1);
    localparam int REF_W  = $clog2(NUM_REF + 1);
    localparam int QRY_W  = $clog2(NUM_QUERY + 1);

    score_t            best_h;
    logic [QRY_W-1:0]  best_idx;
    logic [DIAG_W-1:0] ref_pos;

    // ------------------------------
    // best cell of this anti-diagonal
    // ------------------------------
    always_comb
    begin
        best_h   = '0;      // nothing at or below zero counts
        best_idx = '0;
        for (int k = 0; k < NUM_QUERY; k++)
        begin
            if (cell_valid_i[k] && h_all_i[k] > best_h)   // strict, lowest j wins
            begin
                best_h   = h_all_i[k];
                best_idx = QRY_W'(k);
            end
        end
    end

    assign ref_pos = diag_i - DIAG_W'(best_idx);   // i = (i+j-1) - (j-1)

    // ------------------------------
    // running maximum
    // ------------------------------
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            max_o       <= '0;
            pos_ref_o   <= '0;
            pos_query_o <= '0;
        end
        else if (clear_i)
        begin
            max_o       <= '0;
            pos_ref_o   <= '0;
            pos_query_o <= '0;
        end
        else if (best_h > max_o)
        begin
            max_o       <= best_h;
            pos_ref_o   <= REF_W'(ref_pos);
            pos_query_o <= best_idx + QRY_W'(1);   // 1-based
        end
    end

    // positions stay inside the matrix when a score is held
    a_pos_range : assert property (@(posedge clk) disable iff (reset)
        max_o > 0 |-> (pos_ref_o != 0 && pos_ref_o <= NUM_REF && pos_query_o != 0))
        else $error("sw_max_tracker: position out of range");

endmodule

// ==== hw/sw_top.sv ====
`timescale 1ns/1ps

module sw_top
    import sw_pkg::*;
#(
    parameter int NUM_REF   = 16,
    parameter int NUM_QUERY = 8
)
(
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             valid_i,
    input  base_t                            data_ref_i,
    input  base_t                            data_query_i,
    output logic                             finish_o,
    output score_t                           max_o,
    output logic [$clog2(NUM_REF + 1)-1:0]   pos_ref_o,
    output logic [$clog2(NUM_QUERY + 1)-1:0] pos_query_o
);

    localparam int DIAG_W = $clog2(NUM_REF + NUM_QUERY + 1);

    logic [NUM_QUERY-1:0] query_load;
    logic                 ref_valid;
    logic                 clear;
    logic [DIAG_W-1:0]    diag;
    score_t               h_all [NUM_QUERY];
    logic [NUM_QUERY-1:0] cell_valid;

    // ------------------------------
    // run control
    // ------------------------------
    sw_ctrl #(
        .NUM_REF   (NUM_REF),
        .NUM_QUERY (NUM_QUERY)
    ) u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .valid_i      (valid_i),
        .query_load_o (query_load),
        .ref_valid_o  (ref_valid),
        .clear_o      (clear),
        .diag_o       (diag),
        .finish_o     (finish_o)
    );

    // systolic cells, one per query base
    sw_array #(
        .NUM_QUERY (NUM_QUERY)
    ) u_array (
        .clk          (clk),
        .reset        (reset),
        .query_load_i (query_load),
        .data_query_i (data_query_i),
        .data_ref_i   (data_ref_i),
        .ref_valid_i  (ref_valid),
        .h_all_o      (h_all),
        .cell_valid_o (cell_valid)
    );

    sw_max_tracker #(
        .NUM_REF   (NUM_REF),
        .NUM_QUERY (NUM_QUERY)
    ) u_tracker (
        .clk          (clk),
        .reset        (reset),
        .clear_i      (clear),
        .diag_i       (diag),
        .h_all_i      (h_all),
        .cell_valid_i (cell_valid),
        .max_o        (max_o),
        .pos_ref_o    (pos_ref_o),
        .pos_query_o  (pos_query_o)
    );

endmodule

// ==== sim/sw_model.svh ====
`ifndef SW_MODEL_SVH
`define SW_MODEL_SVH

// expected best local score and its 1-based cell for one sequence pair
// base k of a sequence sits at bits [2*(k-1) +: 2]
function automatic void score_alignment(
    input  logic [2*NUM_REF-1:0]   ref_seq,
    input  logic [2*NUM_QUERY-1:0] query_seq,
    output int                     best,
    output int                     best_ref,
    output int                     best_query
);
    int h     [NUM_REF+1][NUM_QUERY+1];
    int gap_i [NUM_REF+1][NUM_QUERY+1];   // gap along the query
    int gap_d [NUM_REF+1][NUM_QUERY+1];   // gap along the reference
    int r;
    int cand;
    best       = 0;
    best_ref   = 0;
    best_query = 0;

    // row 0 and column 0 lie outside the matrix
    for (int a = 0; a <= NUM_REF; a++)
    begin
        for (int b = 0; b <= NUM_QUERY; b++)
        begin
            h[a][b]     = 0;
            gap_i[a][b] = int'(GAP_OPEN);
            gap_d[a][b] = int'(GAP_OPEN);
        end
    end

    // anti-diagonals in order, low query index first within one
    for (int s = 2; s <= NUM_REF + NUM_QUERY; s++)
    begin
        for (int c = 1; c <= NUM_QUERY; c++)
        begin
            r = s - c;
            if (r >= 1 && r <= NUM_REF)
            begin
                gap_i[r][c] = h[r][c-1] + int'(GAP_OPEN);
                if (gap_i[r][c-1] + int'(GAP_EXTEND) > gap_i[r][c])
                    gap_i[r][c] = gap_i[r][c-1] + int'(GAP_EXTEND);
                gap_d[r][c] = h[r-1][c] + int'(GAP_OPEN);
                if (gap_d[r-1][c] + int'(GAP_EXTEND) > gap_d[r][c])
                    gap_d[r][c] = gap_d[r-1][c] + int'(GAP_EXTEND);
                if (ref_seq[2*(r-1) +: 2] == query_seq[2*(c-1) +: 2])
                    cand = h[r-1][c-1] + int'(MATCH);
                else
                    cand = h[r-1][c-1] + int'(MISMATCH);
                h[r][c] = 0;   // local alignment floor
                if (cand > h[r][c])
                    h[r][c] = cand;
                if (gap_i[r][c] > h[r][c])
                    h[r][c] = gap_i[r][c];
                if (gap_d[r][c] > h[r][c])
                    h[r][c] = gap_d[r][c];
                if (h[r][c] > best)   // strict, a tie keeps the earlier cell
                begin
                    best       = h[r][c];
                    best_ref   = r;
                    best_query = c;
                end
            end
        end
    end
endfunction

`endif

// ==== sim/sw_tb.sv ====
`timescale 1ns/1ps

module sw_tb
    import sw_pkg::*;
();

    localparam int NUM_REF    = 16;
    localparam int NUM_QUERY  = 8;
    localparam int NUM_TESTS  = 12;
    localparam int LATENCY    = NUM_REF + NUM_QUERY + 1;   // first valid edge to finish
    localparam int CLK_PERIOD = 20;

    logic                             clk;
    logic                             reset;
    logic                             valid_i;
    base_t                            data_ref_i;
    base_t                            data_query_i;
    logic                             finish_o;
    score_t                           max_o;
    logic [$clog2(NUM_REF + 1)-1:0]   pos_ref_o;
    logic [$clog2(NUM_QUERY + 1)-1:0] pos_query_o;

    // ------------------------------
    // stimulus table
    // ------------------------------
    logic [2*NUM_REF-1:0]   tbl_ref       [NUM_TESTS];
    logic [2*NUM_QUERY-1:0] tbl_query     [NUM_TESTS];
    int                     tbl_score     [NUM_TESTS];
    int                     tbl_pos_ref   [NUM_TESTS];
    int                     tbl_pos_query [NUM_TESTS];

    int seed       = 32'hfead_bdb9;
    int cycle_cnt  = 0;   // posedges since time zero
    int err_count  = 0;
    int fail_tests = 0;

    `include "sw_model.svh"

    sw_top uut (
        .clk          (clk),
        .reset        (reset),
        .valid_i      (valid_i),
        .data_ref_i   (data_ref_i),
        .data_query_i (data_query_i),
        .finish_o     (finish_o),
        .max_o        (max_o),
        .pos_ref_o    (pos_ref_o),
        .pos_query_o  (pos_query_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    // copy query bases first..last into seq from reference position pos on
    function automatic logic [2*NUM_REF-1:0] copy_bases(
        input logic [2*NUM_REF-1:0]   seq,
        input int                     pos,
        input logic [2*NUM_QUERY-1:0] q,
        input int                     first,
        input int                     last
    );
        logic [2*NUM_REF-1:0] res;
        res = seq;
        for (int k = first; k <= last; k++)
            res[2*(pos+k-first-1) +: 2] = q[2*(k-1) +: 2];
        return res;
    endfunction

    task automatic build_table();
        logic [2*NUM_QUERY-1:0] q;
        q = {2'd2, 2'd3, 2'd1, 2'd2, 2'd3, 2'd3, 2'd2, 2'd1};   // base 8 down to 1, no A
        tbl_ref[0]   = copy_bases('0, 6, q, 1, NUM_QUERY);      // full copy at 6..13
        tbl_query[0] = q;
        tbl_ref[1]   = '0;                                      // nothing in common
        tbl_query[1] = q;
        // one extra reference base after query base 4
        tbl_ref[2]   = copy_bases(copy_bases('0, 3, q, 1, 4), 8, q, 5, NUM_QUERY);
        tbl_query[2] = q;
        // three extra bases, gap open then two extends
        tbl_ref[3]   = copy_bases(copy_bases('0, 3, q, 1, 4), 10, q, 5, NUM_QUERY);
        tbl_query[3] = q;
        for (int t = 4; t < NUM_TESTS; t++)
        begin
            for (int k = 0; k < NUM_REF; k++)
                tbl_ref[t][2*k +: 2] = base_t'($random(seed));
            for (int k = 0; k < NUM_QUERY; k++)
                tbl_query[t][2*k +: 2] = base_t'($random(seed));
        end
        for (int t = 0; t < NUM_TESTS; t++)
            score_alignment(tbl_ref[t], tbl_query[t], tbl_score[t], tbl_pos_ref[t],
                            tbl_pos_query[t]);
    endtask

    task automatic report_mismatch(input string where, input string name,
                                   input int expected, input int actual);
        $display("ERR %s: %s expected %h got %h", where, name, expected, actual);
        err_count++;
    endtask

    // ------------------------------
    // one run of the aligner
    // ------------------------------
    task automatic run_test(input int idx);
        int    e0;
        int    errs_before;
        logic  seen;
        string where;
        string status;
        where       = $sformatf("test %0d", idx);
        errs_before = err_count;
        e0          = cycle_cnt + 1;   // edge that samples the first base
        for (int k = 0; k < NUM_REF; k++)
        begin
            valid_i    = 1'b1;
            data_ref_i = tbl_ref[idx][2*k +: 2];
            if (k < NUM_QUERY)
                data_query_i = tbl_query[idx][2*k +: 2];
            else
                data_query_i = base_t'($random(seed));   // ignored past the query
            @(negedge clk);
            if (finish_o !== 1'b0)
            begin
                $display("%s: finish_o rose while the sequences were loading", where);
                err_count++;
            end
        end
        valid_i      = 1'b0;
        data_ref_i   = '0;
        data_query_i = '0;

        seen = 1'b0;
        while (!seen && cycle_cnt - e0 < 2 * LATENCY)
        begin
            @(negedge clk);
            seen = (finish_o === 1'b1);
        end
        if (!seen)
        begin
            $display("%s: finish_o never rose", where);
            err_count++;
        end
        else
        begin
            if (cycle_cnt - e0 != LATENCY)
                report_mismatch(where, "finish_o latency", LATENCY, cycle_cnt - e0);
            if (int'(max_o) != tbl_score[idx])
                report_mismatch(where, "max_o", tbl_score[idx], int'(max_o));
            if (int'(pos_ref_o) != tbl_pos_ref[idx])
                report_mismatch(where, "pos_ref_o", tbl_pos_ref[idx], int'(pos_ref_o));
            if (int'(pos_query_o) != tbl_pos_query[idx])
                report_mismatch(where, "pos_query_o", tbl_pos_query[idx], int'(pos_query_o));
            @(negedge clk);
            if (finish_o !== 1'b0)
            begin
                $display("%s: finish_o stayed high for more than one cycle", where);
                err_count++;
            end
        end

        status = (err_count == errs_before) ? "passed" : "FAILED";
        if (err_count != errs_before)
            fail_tests++;
        $display("%s %s: score %0d at ref %0d query %0d", where, status, max_o,
                 pos_ref_o, pos_query_o);
    endtask

    initial
    begin
        reset        = 1'b1;
        valid_i      = 1'b0;
        data_ref_i   = '0;
        data_query_i = '0;
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // idle outputs after reset
        if (finish_o !== 1'b0)
            report_mismatch("reset", "finish_o", 0, int'(finish_o));
        if (max_o !== '0)
            report_mismatch("reset", "max_o", 0, int'(max_o));
        if (pos_ref_o !== '0)
            report_mismatch("reset", "pos_ref_o", 0, int'(pos_ref_o));
        if (pos_query_o !== '0)
            report_mismatch("reset", "pos_query_o", 0, int'(pos_query_o));

        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);   // back to back, each run must clear the last maximum

        $display("%0d of %0d tests failed, %0d errors", fail_tests, NUM_TESTS, err_count);
        if (err_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // watchdog sized from the test count and the run length
    initial
    begin
        #((NUM_TESTS * (NUM_REF + NUM_QUERY + 10) + 10) * CLK_PERIOD);
        $display("timeout: the tests did not complete in the expected time");
        $display("Errors found");
        $finish;
    end

endmodule

// ==== sw_align.f ====
+incdir+sim
hw/sw_pkg.sv
hw/sw_pe.sv
hw/sw_array.sv
hw/sw_ctrl.sv
hw/sw_max_tracker.sv
hw/sw_top.sv
sim/sw_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the sw_align testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module sw_tb -Mdir obj_dir -o sw_tb_sim \
    -f sw_align.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sw_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "No errors" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
exit 0
